/* source/vector_bus_pkg.sv */
// ================================================
// Bus widths, status word bits and I/O port map
// shared by the glue logic around the 8080 bus
// ================================================
`default_nettype none

package vector_bus_pkg;

    typedef logic [15:0] addr_t;
    typedef logic [7:0]  data_t;
    // Page 0 is main RAM and pages 1 to 4 are the RAM disk
    typedef logic [2:0]  ed_page_t;

    // ================================================
    // Status word bit positions
    localparam int ST_INT_ACK  = 0;
    localparam int ST_WRITE_N  = 1;
    localparam int ST_STACK    = 2;
    localparam int ST_IO_WRITE = 4;
    localparam int ST_IO_READ  = 6;
    localparam int ST_RAM_READ = 7;

    // ================================================
    // Port map on the low address byte
    // Bit write at 04 and whole byte write at 05
    localparam data_t PORT_JOY_CTRL = 8'h04;
    localparam data_t PORT_JOY_P    = 8'h06;
    localparam data_t PORT_COVOX    = 8'h07;
    localparam data_t PORT_JOY_A    = 8'h0E;
    localparam data_t PORT_JOY_B    = 8'h0F;
    localparam data_t PORT_EDISK    = 8'h10;
    // PSG occupies 14 and 15
    localparam data_t PORT_PSG      = 8'h14;

    // Floating bus value
    localparam data_t BUS_IDLE = 8'hFF;

endpackage

`default_nettype wire

/* source/vector_audio_pkg.sv */
// ================================================
// Sample widths and covox start-up lockout for the
// sound path
// ================================================
`default_nettype none

package vector_audio_pkg;

    typedef logic [7:0]  psg_level_t;
    typedef logic [15:0] sample_t;

    // Covox writes are ignored this many cycles after reset
    localparam int COVOX_LOCK_CYCLES = 64;
    localparam int COVOX_LOCK_W      = $clog2(COVOX_LOCK_CYCLES + 1);

endpackage

`default_nettype wire

/* source/bus_control.sv */
// ================================================
// Status word latch, port decode, write pulses and
// read byte select for the processor bus
// ================================================
`timescale 1ns/1ps
`default_nettype none

module bus_control (
    input  wire                    clk_sys,
    input  wire                    reset,
    input  wire vector_bus_pkg::addr_t cpu_addr_i,
    input  wire vector_bus_pkg::data_t cpu_data_i,
    input  wire                    cpu_sync_i,
    input  wire                    cpu_wr_n_i,
    input  wire vector_bus_pkg::data_t ram_data_i,
    input  wire vector_bus_pkg::data_t psg_data_i,
    input  wire vector_bus_pkg::data_t joy_p_i,
    input  wire vector_bus_pkg::data_t joy_pu_i,
    input  wire vector_bus_pkg::data_t joy_a_i,
    input  wire vector_bus_pkg::data_t joy_b_i,
    output vector_bus_pkg::data_t  cpu_din_o,
    output logic                   mem_access_o,
    output logic                   stack_access_o,
    output logic                   edisk_we_o,
    output logic                   joy_we_o,
    output logic                   joy_whole_o,
    output logic                   covox_we_o,
    output logic                   psg_we_o
);
    import vector_bus_pkg::*;

    data_t       status_q;
    logic        sync_q;
    logic        io_wr;
    logic        io_wr_q;
    logic        io_wr_start;
    data_t       port;
    logic        joy_sel;
    logic        psg_sel;
    data_t       io_data;
    logic [3:0]  we_vec;

    // ================================================
    // Status word
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            sync_q   <= 1'b0;
            status_q <= '0;
        end else begin
            sync_q <= cpu_sync_i;
            if (cpu_sync_i && !sync_q)
                status_q <= cpu_data_i;
        end
    end

    assign mem_access_o   = status_q[ST_RAM_READ] | ~status_q[ST_WRITE_N];
    assign stack_access_o = status_q[ST_STACK];

    // ================================================
    // Port decode and write pulses
    assign port    = cpu_addr_i[7:0];
    assign joy_sel = (port[7:1] == PORT_JOY_CTRL[7:1]);
    assign psg_sel = (port[7:1] == PORT_PSG[7:1]);

    assign io_wr = status_q[ST_IO_WRITE] & ~cpu_wr_n_i;

    always_ff @(posedge clk_sys) begin
        if (reset)
            io_wr_q <= 1'b0;
        else
            io_wr_q <= io_wr;
    end

    // Only the first cycle of a write level counts
    assign io_wr_start = io_wr & ~io_wr_q;

    assign edisk_we_o  = io_wr_start & (port == PORT_EDISK);
    assign joy_we_o    = io_wr_start & joy_sel;
    assign joy_whole_o = port[0];
    assign covox_we_o  = io_wr_start & (port == PORT_COVOX);
    assign psg_we_o    = io_wr_start & psg_sel;

    // ================================================
    // Read byte
    always_comb begin
        io_data = BUS_IDLE;
        if (joy_sel) begin
            io_data = '0;
        end else if (psg_sel) begin
            io_data = psg_data_i;
        end else begin
            case (port)
                PORT_JOY_P: io_data = joy_p_i;
                PORT_COVOX: io_data = joy_pu_i;
                PORT_JOY_A: io_data = joy_a_i;
                PORT_JOY_B: io_data = joy_b_i;
                default:    io_data = BUS_IDLE;
            endcase
        end
    end

    always_comb begin
        if (status_q[ST_INT_ACK])
            cpu_din_o = BUS_IDLE;
        else if (status_q[ST_IO_READ])
            cpu_din_o = io_data;
        else
            cpu_din_o = ram_data_i;
    end

    assign we_vec = {edisk_we_o, joy_we_o, covox_we_o, psg_we_o};

    // One target per I/O write
    a_one_pulse: assert property (@(posedge clk_sys) disable iff (reset)
        $onehot0(we_vec));

endmodule

`default_nettype wire

/* source/edisk_mapper.sv */
// ================================================
// RAM-disk page register and address to page map
// ================================================
`timescale 1ns/1ps
`default_nettype none

module edisk_mapper (
    input  wire                        clk_sys,
    input  wire                        reset,
    input  wire                        edisk_we_i,
    input  wire vector_bus_pkg::data_t cpu_data_i,
    input  wire vector_bus_pkg::addr_t cpu_addr_i,
    input  wire                        mem_access_i,
    input  wire                        stack_access_i,
    output vector_bus_pkg::ed_page_t   ed_page_o
);
    import vector_bus_pkg::*;

    data_t ed_reg;
    logic  win_open;
    logic  stack_hit;
    logic  win_hit;

    always_ff @(posedge clk_sys) begin
        if (reset)
            ed_reg <= '0;
        else if (edisk_we_i)
            ed_reg <= cpu_data_i;
    end

    // Window in the upper half, bits 7 and 6 open the outer quarters
    assign win_open = cpu_addr_i[15] &
                      ((cpu_addr_i[14] ^ cpu_addr_i[13]) |
                       (ed_reg[7] & cpu_addr_i[14] & cpu_addr_i[13]) |
                       (ed_reg[6] & ~cpu_addr_i[14] & ~cpu_addr_i[13]));

    assign stack_hit = ed_reg[4] & stack_access_i & mem_access_i;
    assign win_hit   = ed_reg[5] & win_open & mem_access_i;

    // Stack mapping wins over the window
    always_comb begin
        if (stack_hit)
            ed_page_o = {1'b0, ed_reg[3:2]} + 3'd1;
        else if (win_hit)
            ed_page_o = {1'b0, ed_reg[1:0]} + 3'd1;
        else
            ed_page_o = '0;
    end

    a_page_range: assert property (@(posedge clk_sys) disable iff (reset)
        (ed_page_o != '0) |-> (ed_page_o <= 3'd4) && mem_access_i);

endmodule

`default_nettype wire

/* source/joystick_port.sv */
// ================================================
// Joystick port register and the readback bytes of
// ports 06, 07, 0E and 0F
// ================================================
`timescale 1ns/1ps
`default_nettype none

module joystick_port (
    input  wire                        clk_sys,
    input  wire                        reset,
    input  wire                        joy_we_i,
    input  wire                        joy_whole_i,
    input  wire vector_bus_pkg::data_t cpu_data_i,
    input  wire vector_bus_pkg::data_t joy_a_i,
    input  wire vector_bus_pkg::data_t joy_b_i,
    output vector_bus_pkg::data_t      joy_p_o,
    output vector_bus_pkg::data_t      joy_pu_o,
    output vector_bus_pkg::data_t      joy_a_o,
    output vector_bus_pkg::data_t      joy_b_o
);
    import vector_bus_pkg::*;

    data_t joy_reg;
    data_t joy_pu;

    // Active low reorder of one pad, two fixed zeros in the middle
    function automatic data_t pad_order(input data_t raw);
        data_t ordered;
        ordered = {raw[5], raw[4], 2'b00, raw[2], raw[3], raw[1], raw[0]};
        return ~ordered;
    endfunction

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            joy_reg <= '0;
        end else if (joy_we_i) begin
            if (joy_whole_i)
                joy_reg <= cpu_data_i;
            else if (!cpu_data_i[7])
                joy_reg[cpu_data_i[3:1]] <= cpu_data_i[0];
        end
    end

    assign joy_a_o = pad_order(joy_a_i);
    assign joy_b_o = pad_order(joy_b_i);

    // Both pads merged, active high
    assign joy_pu   = joy_a_i | joy_b_i;
    assign joy_pu_o = {joy_pu[3], joy_pu[0], joy_pu[2], joy_pu[1],
                       joy_pu[4], joy_pu[5], 2'b00};

    always_comb begin
        case (joy_reg[6:5])
            2'd0:    joy_p_o = joy_a_o & joy_b_o;
            2'd1:    joy_p_o = joy_a_o;
            2'd2:    joy_p_o = joy_b_o;
            default: joy_p_o = '1;
        endcase
    end

endmodule

`default_nettype wire

/* source/covox_dac.sv */
// ================================================
// Covox DAC register with a write lockout after reset
// ================================================
`timescale 1ns/1ps
`default_nettype none

module covox_dac (
    input  wire                        clk_sys,
    input  wire                        reset,
    input  wire                        covox_we_i,
    input  wire vector_bus_pkg::data_t cpu_data_i,
    output vector_bus_pkg::data_t      covox_o
);
    import vector_audio_pkg::*;

    logic [COVOX_LOCK_W-1:0] lock_cnt;
    logic                    locked;

    assign locked = (lock_cnt != '0);

    // Lockout counter runs down once and then stays at zero
    always_ff @(posedge clk_sys) begin
        if (reset)
            lock_cnt <= COVOX_LOCK_W'(COVOX_LOCK_CYCLES);
        else if (locked)
            lock_cnt <= lock_cnt - 1'b1;
    end

    always_ff @(posedge clk_sys) begin
        if (reset)
            covox_o <= '0;
        else if (covox_we_i && !locked)
            covox_o <= cpu_data_i;
    end

    a_lockout: assert property (@(posedge clk_sys) disable iff (reset)
        locked |=> $stable(covox_o));

endmodule

`default_nettype wire

/* source/audio_mixer.sv */
// ================================================
// Registered left/right mix of PSG, beeper and covox
// ================================================
`timescale 1ns/1ps
`default_nettype none

module audio_mixer (
    input  wire                              clk_sys,
    input  wire                              reset,
    input  wire vector_audio_pkg::psg_level_t psg_a_i,
    input  wire vector_audio_pkg::psg_level_t psg_b_i,
    input  wire vector_audio_pkg::psg_level_t psg_c_i,
    input  wire [5:0]                        psg_active_i,
    input  wire [2:0]                        tone_i,
    input  wire vector_bus_pkg::data_t       covox_i,
    output vector_audio_pkg::sample_t        left_o,
    output vector_audio_pkg::sample_t        right_o
);

    logic [1:0]  beeper;
    // Largest sum is 3*256 + 2*255, which fits in 11 bits
    logic [10:0] mix_l;
    logic [10:0] mix_r;

    assign beeper = 2'(tone_i[0]) + 2'(tone_i[1]) + 2'(tone_i[2]);

    always_comb begin
        if (|psg_active_i) begin
            mix_l = (11'(psg_a_i) << 1) + 11'(psg_b_i) + (11'(beeper) << 7);
            mix_r = (11'(psg_c_i) << 1) + 11'(psg_b_i) + (11'(beeper) << 7);
        end else begin
            mix_l = (11'(beeper) << 8) + (11'(covox_i) << 1);
            mix_r = mix_l;
        end
    end

    // Scale by 32 into the 16-bit sample
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            left_o  <= '0;
            right_o <= '0;
        end else begin
            left_o  <= {mix_l, 5'd0};
            right_o <= {mix_r, 5'd0};
        end
    end

endmodule

`default_nettype wire

/* source/vector_glue_top.sv */
// ================================================
// Top of the I/O glue between the processor bus and
// the small peripherals
// ================================================
`timescale 1ns/1ps
`default_nettype none

module vector_glue_top (
    input  wire                               clk_sys,
    input  wire                               reset,
    input  wire vector_bus_pkg::addr_t        cpu_addr_i,
    input  wire vector_bus_pkg::data_t        cpu_data_i,
    input  wire                               cpu_sync_i,
    input  wire                               cpu_wr_n_i,
    input  wire vector_bus_pkg::data_t        ram_data_i,
    input  wire vector_bus_pkg::data_t        psg_data_i,
    input  wire vector_audio_pkg::psg_level_t psg_a_i,
    input  wire vector_audio_pkg::psg_level_t psg_b_i,
    input  wire vector_audio_pkg::psg_level_t psg_c_i,
    input  wire [5:0]                         psg_active_i,
    input  wire [2:0]                         tone_i,
    input  wire vector_bus_pkg::data_t        joy_a_i,
    input  wire vector_bus_pkg::data_t        joy_b_i,
    output vector_bus_pkg::data_t             cpu_din_o,
    output vector_bus_pkg::ed_page_t          ed_page_o,
    output vector_audio_pkg::sample_t         left_o,
    output vector_audio_pkg::sample_t         right_o
);
    import vector_bus_pkg::*;

    logic  mem_access;
    logic  stack_access;
    logic  edisk_we;
    logic  joy_we;
    logic  joy_whole;
    logic  covox_we;
    data_t joy_p;
    data_t joy_pu;
    data_t joy_a;
    data_t joy_b;
    data_t covox;

    // PSG write strobe is left open since the PSG core lives outside
    bus_control i_bus_control (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .cpu_addr_i     (cpu_addr_i),
        .cpu_data_i     (cpu_data_i),
        .cpu_sync_i     (cpu_sync_i),
        .cpu_wr_n_i     (cpu_wr_n_i),
        .ram_data_i     (ram_data_i),
        .psg_data_i     (psg_data_i),
        .joy_p_i        (joy_p),
        .joy_pu_i       (joy_pu),
        .joy_a_i        (joy_a),
        .joy_b_i        (joy_b),
        .cpu_din_o      (cpu_din_o),
        .mem_access_o   (mem_access),
        .stack_access_o (stack_access),
        .edisk_we_o     (edisk_we),
        .joy_we_o       (joy_we),
        .joy_whole_o    (joy_whole),
        .covox_we_o     (covox_we),
        .psg_we_o       ()
    );

    edisk_mapper i_edisk_mapper (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .edisk_we_i     (edisk_we),
        .cpu_data_i     (cpu_data_i),
        .cpu_addr_i     (cpu_addr_i),
        .mem_access_i   (mem_access),
        .stack_access_i (stack_access),
        .ed_page_o      (ed_page_o)
    );

    joystick_port i_joystick_port (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .joy_we_i    (joy_we),
        .joy_whole_i (joy_whole),
        .cpu_data_i  (cpu_data_i),
        .joy_a_i     (joy_a_i),
        .joy_b_i     (joy_b_i),
        .joy_p_o     (joy_p),
        .joy_pu_o    (joy_pu),
        .joy_a_o     (joy_a),
        .joy_b_o     (joy_b)
    );

    covox_dac i_covox_dac (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .covox_we_i (covox_we),
        .cpu_data_i (cpu_data_i),
        .covox_o    (covox)
    );

    audio_mixer i_audio_mixer (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .psg_a_i      (psg_a_i),
        .psg_b_i      (psg_b_i),
        .psg_c_i      (psg_c_i),
        .psg_active_i (psg_active_i),
        .tone_i       (tone_i),
        .covox_i      (covox),
        .left_o       (left_o),
        .right_o      (right_o)
    );

endmodule

`default_nettype wire

/* test/tb_vector_glue.sv */
// ================================================
// Testbench for the I/O glue: bus cycles from the
// vectors file, then covox lockout and mixer runs
// ================================================
`timescale 1ns/1ps
`default_nettype none

module tb_vector_glue;
    import vector_bus_pkg::*;
    import vector_audio_pkg::*;

    localparam data_t IO_WRITE_STATUS = data_t'(1 << ST_IO_WRITE);
    localparam data_t IO_READ_STATUS  = data_t'((1 << ST_IO_READ) | (1 << ST_WRITE_N));
    localparam int    WAIT_LIMIT      = 1000;
    localparam int    LINE_LIMIT      = 500;
    localparam int    MIX_ROUNDS      = 24;

    logic        clk_sys;
    logic        reset;
    logic [15:0] cpu_addr_i;
    logic [7:0]  cpu_data_i;
    logic        cpu_sync_i;
    logic        cpu_wr_n_i;
    logic [7:0]  ram_data_i;
    logic [7:0]  psg_data_i;
    logic [7:0]  psg_a_i;
    logic [7:0]  psg_b_i;
    logic [7:0]  psg_c_i;
    logic [5:0]  psg_active_i;
    logic [2:0]  tone_i;
    logic [7:0]  joy_a_i;
    logic [7:0]  joy_b_i;
    wire  [7:0]  cpu_din_o;
    wire  [2:0]  ed_page_o;
    wire  [15:0] left_o;
    wire  [15:0] right_o;

    logic [31:0] lfsr_state;
    int          run_cycles;

    vector_glue_top i_dut (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .cpu_addr_i   (cpu_addr_i),
        .cpu_data_i   (cpu_data_i),
        .cpu_sync_i   (cpu_sync_i),
        .cpu_wr_n_i   (cpu_wr_n_i),
        .ram_data_i   (ram_data_i),
        .psg_data_i   (psg_data_i),
        .psg_a_i      (psg_a_i),
        .psg_b_i      (psg_b_i),
        .psg_c_i      (psg_c_i),
        .psg_active_i (psg_active_i),
        .tone_i       (tone_i),
        .joy_a_i      (joy_a_i),
        .joy_b_i      (joy_b_i),
        .cpu_din_o    (cpu_din_o),
        .ed_page_o    (ed_page_o),
        .left_o       (left_o),
        .right_o      (right_o)
    );

    always #4 clk_sys = ~clk_sys;

    // RAM contents follow the whole address
    assign ram_data_i = cpu_addr_i[15:8] ^ cpu_addr_i[7:0];

    always @(posedge clk_sys) begin
        if (reset)
            run_cycles <= 0;
        else
            run_cycles <= run_cycles + 1;
    end

    // ================================================
    // Reporting
    task automatic check_equal(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (expected == actual) else begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("Error: %s", reason);
        $display("Something failed");
        $fatal(1);
    endtask

    // ================================================
    // Random levels and expected samples
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'h8020_0003;
        return n;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < count; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic int beeper_level(input logic [2:0] t);
        return int'(t[0]) + int'(t[1]) + int'(t[2]);
    endfunction

    // Twice the side channel plus B plus half-weight beeper, scaled by 32
    function automatic logic [15:0] psg_mix(input logic [7:0] side, input logic [7:0] mid,
                                            input logic [2:0] t);
        return 16'((2 * int'(side) + int'(mid) + 128 * beeper_level(t)) * 32);
    endfunction

    function automatic logic [15:0] silent_mix(input logic [2:0] t, input logic [7:0] cov);
        return 16'((256 * beeper_level(t) + 2 * int'(cov)) * 32);
    endfunction

    // ================================================
    // Bus handling
    task automatic wait_clocks(input int count);
        int waited;
        waited = 0;
        while (waited < count) begin
            @(posedge clk_sys);
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run("clock wait ran past its limit");
        end
    endtask

    // Sync edge latches the status, then address and write level follow
    task automatic run_bus_cycle(input logic [15:0] addr, input logic [7:0] status,
                                 input logic write, input logic [7:0] data);
        @(posedge clk_sys);
        #1;
        cpu_addr_i = addr;
        cpu_data_i = status;
        cpu_sync_i = 1'b1;
        cpu_wr_n_i = 1'b1;
        @(posedge clk_sys);
        #1;
        cpu_sync_i = 1'b0;
        cpu_data_i = data;
        cpu_wr_n_i = !write;
        wait_clocks(3);
        #1;
        cpu_wr_n_i = 1'b1;
    endtask

    task automatic wait_lockout();
        int guard;
        guard = 0;
        while (run_cycles < COVOX_LOCK_CYCLES + 2) begin
            @(posedge clk_sys);
            guard++;
            if (guard > WAIT_LIMIT)
                abort_run("covox lockout never ran out");
        end
    endtask

    // ================================================
    // Vector file
    task automatic run_vectors();
        int          fd;
        int          fields;
        int          lines;
        string       line;
        logic [7:0]  op;
        logic [15:0] f1;
        logic [15:0] f2;
        logic [15:0] f3;
        fd = $fopen("test/glue_vectors.txt", "r");
        if (fd == 0)
            abort_run("cannot open test/glue_vectors.txt");
        lines = 0;
        while (!$feof(fd)) begin
            lines++;
            if (lines > LINE_LIMIT)
                abort_run("vectors file has too many lines");
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == 8'h23)
                continue;
            f3 = '0;
            fields = $sscanf(line, "%c %h %h %h", op, f1, f2, f3);
            case (op)
                "W": run_bus_cycle(f1, IO_WRITE_STATUS, 1'b1, f2[7:0]);
                "R": begin
                    run_bus_cycle(f1, (fields == 4) ? f3[7:0] : IO_READ_STATUS,
                                  1'b0, 8'h00);
                    check_equal($sformatf("read %h", f1), f2, {8'h00, cpu_din_o});
                end
                "P": begin
                    run_bus_cycle(f1, f2[7:0], 1'b0, 8'h00);
                    check_equal($sformatf("page %h/%h", f1, f2), f3, {13'd0, ed_page_o});
                end
                "J": begin
                    @(posedge clk_sys);
                    #1;
                    joy_a_i = f1[7:0];
                    joy_b_i = f2[7:0];
                end
                default: abort_run($sformatf("unknown vector line: %s", line));
            endcase
        end
        $fclose(fd);
    endtask

    // ================================================
    // Main sequence
    initial begin
        logic [15:0] exp_l;
        logic [15:0] exp_r;
        clk_sys      = 1'b0;
        reset        = 1'b1;
        cpu_addr_i   = '0;
        cpu_data_i   = '0;
        cpu_sync_i   = 1'b0;
        cpu_wr_n_i   = 1'b1;
        psg_data_i   = 8'hA5;
        psg_a_i      = '0;
        psg_b_i      = '0;
        psg_c_i      = '0;
        psg_active_i = '0;
        tone_i       = 3'b011;
        joy_a_i      = '0;
        joy_b_i      = '0;
        lfsr_state   = 32'h4d77_0a8e;
        wait_clocks(2);
        #1;
        reset = 1'b0;

        // Early covox write falls inside the lockout
        run_bus_cycle(16'h0007, IO_WRITE_STATUS, 1'b1, 8'h80);
        check_equal("covox locked left", silent_mix(tone_i, 8'h00), left_o);
        check_equal("covox locked right", silent_mix(tone_i, 8'h00), right_o);

        run_vectors();

        wait_lockout();
        run_bus_cycle(16'h0007, IO_WRITE_STATUS, 1'b1, 8'h80);
        check_equal("covox left", silent_mix(tone_i, 8'h80), left_o);
        check_equal("covox right", silent_mix(tone_i, 8'h80), right_o);

        // PSG path, one cycle from input to sample
        @(posedge clk_sys);
        #1;
        exp_l = '0;
        exp_r = '0;
        for (int k = 0; k <= MIX_ROUNDS; k++) begin
            if (k > 0) begin
                @(posedge clk_sys);
                #1;
                check_equal($sformatf("mix left %0d", k), exp_l, left_o);
                check_equal($sformatf("mix right %0d", k), exp_r, right_o);
            end
            psg_a_i      = 8'(random_bits(8));
            psg_b_i      = 8'(random_bits(8));
            psg_c_i      = 8'(random_bits(8));
            psg_active_i = 6'(random_bits(6));
            if (psg_active_i == '0)
                psg_active_i = 6'b000001;
            tone_i = 3'(random_bits(3));
            exp_l  = psg_mix(psg_a_i, psg_b_i, tone_i);
            exp_r  = psg_mix(psg_c_i, psg_b_i, tone_i);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* test/glue_vectors.txt */
# W port data | R address expected [status] | P address status page
# J joystick A and B input bytes; all fields hex
R 0004 00
R 0005 00
R 003A FF
R 0015 A5
R 1234 26 82
J 21 0C
R 000E 7E
R 000F F3
R 0007 E4
R 0006 72
R 0006 FF 43
W 0005 20
R 0006 7E
W 0004 0D
R 0006 FF
W 0004 0A
R 0006 F3
W 0004 8C
R 0006 F3
J 3F 00
R 000E 30
R 000F FF
R 0007 FC
W 0005 00
R 0006 30
W 0010 25
P A000 82 2
P C000 82 2
P E000 82 0
P 2000 82 0
P A000 42 0
P A000 00 2
W 0010 DB
P E000 82 0
P 1000 86 3
P 1000 04 3
W 0010 F3
P E000 82 4
P 8000 82 4
P 8000 86 1
P 4000 82 0

/* list.f */
source/vector_bus_pkg.sv
source/vector_audio_pkg.sv
source/bus_control.sv
source/edisk_mapper.sv
source/joystick_port.sv
source/covox_dac.sv
source/audio_mixer.sv
source/vector_glue_top.sv
test/tb_vector_glue.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_vector_glue
FILELIST  = list.f
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
PASS_MSG  = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJDIR) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(BIN) | awk '{ print } /^$(PASS_MSG)$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJDIR)
